/* Makefile */
TOP = tb_ppu_bg

all: run

obj_dir/V$(TOP): list.f *.sv
	verilator --binary --timing --assert -f list.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

lint:
	verilator --lint-only --timing -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean

/* bg_fetcher.sv */
module bg_fetcher (
  input  logic        clk,
  input  logic        reset,
  input  logic        line_start,
  input  logic [7:0]  lcdc,
  input  logic [7:0]  scx,
  input  logic [7:0]  scy,
  input  logic [7:0]  ly,
  input  logic [7:0]  vram_rdata,
  input  logic        row_empty,
  output logic [12:0] vram_addr,
  output logic        vram_rd,
  output logic        row_valid,
  output logic [7:0]  row_lo,
  output logic [7:0]  row_hi
);

  // Current fetch step
  logic [2:0] state;

  // Tile map column, already offset by the coarse scroll
  logic [4:0] tile_col;

  // Rows handed to the shifter in this line
  logic [4:0] rows_pushed;

  // Tile index latched from the map read
  ppu_pkg::tile_id_u tile_id;

  // Background line inside the 256 pixel map, wraps past 255
  logic [7:0] map_y;

  // Pixel row inside the tile
  logic [2:0] fine_row;

  logic [12:0] map_base;
  logic [12:0] map_addr;
  logic [12:0] tile_base;
  logic [12:0] tile_addr;

  assign map_y    = scy + ly;
  assign fine_row = map_y[2:0];

  // Map select from LCDC bit 3
  assign map_base = lcdc[3] ? ppu_pkg::map_base_high : ppu_pkg::map_base_low;

  // 32 entries per map row, column wraps at 32 by width
  assign map_addr = map_base + {3'b000, map_y[7:3], tile_col};

  // 16 bytes per tile
  // Signed view is sign extended so indices 0x80..0xFF land below 0x1000
  always_comb begin
    if (lcdc[4]) begin
      tile_base = ppu_pkg::data_base_unsigned + {1'b0, tile_id.idx_u, 4'h0};
    end else begin
      tile_base = ppu_pkg::data_base_signed + {tile_id.idx_s[7], tile_id.idx_s, 4'h0};
    end
  end

  // Two bytes per tile row, low byte first
  assign tile_addr = tile_base + {9'b0, fine_row, 1'b0};

  // Read strobe only in request cycles
  assign vram_rd = (state == ppu_pkg::fs_map_req) ||
                   (state == ppu_pkg::fs_lo_req) ||
                   (state == ppu_pkg::fs_hi_req);

  always_comb begin
    case (state)
      ppu_pkg::fs_map_req: vram_addr = map_addr;
      ppu_pkg::fs_lo_req:  vram_addr = tile_addr;
      // High bitplane follows the low one
      ppu_pkg::fs_hi_req:  vram_addr = tile_addr + 13'd1;
      default:             vram_addr = 13'h0000;
    endcase
  end

  // Hand over only into an empty row buffer
  assign row_valid = (state == ppu_pkg::fs_push) && row_empty;

  // Fetch sequencing
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state       <= ppu_pkg::fs_idle;
      tile_col    <= 5'd0;
      rows_pushed <= 5'd0;
    end else if (line_start) begin
      // Restart from the coarse scroll column
      state       <= ppu_pkg::fs_map_req;
      tile_col    <= scx[7:3];
      rows_pushed <= 5'd0;
    end else begin
      case (state)
        ppu_pkg::fs_map_req: state <= ppu_pkg::fs_map_dat;
        ppu_pkg::fs_map_dat: state <= ppu_pkg::fs_lo_req;
        ppu_pkg::fs_lo_req:  state <= ppu_pkg::fs_lo_dat;
        ppu_pkg::fs_lo_dat:  state <= ppu_pkg::fs_hi_req;
        ppu_pkg::fs_hi_req:  state <= ppu_pkg::fs_hi_dat;
        ppu_pkg::fs_hi_dat:  state <= ppu_pkg::fs_push;
        ppu_pkg::fs_push: begin
          // Hold here while the shifter still has pixels
          if (row_empty) begin
            tile_col    <= tile_col + 5'd1;
            rows_pushed <= rows_pushed + 5'd1;
            if (rows_pushed == ppu_pkg::rows_per_line - 5'd1) begin
              state <= ppu_pkg::fs_idle;
            end else begin
              state <= ppu_pkg::fs_map_req;
            end
          end
        end
        // Idle until the next line_start
        default: state <= ppu_pkg::fs_idle;
      endcase
    end
  end

  // Read data capture, one cycle after each request
  always_ff @(posedge clk) begin
    case (state)
      ppu_pkg::fs_map_dat: tile_id <= vram_rdata;
      ppu_pkg::fs_lo_dat:  row_lo  <= vram_rdata;
      ppu_pkg::fs_hi_dat:  row_hi  <= vram_rdata;
      default: ;
    endcase
  end

endmodule

/* lcd_regs.sv */
module lcd_regs (
  input  logic       clk,
  input  logic       reset,
  input  logic       wb_cyc,
  input  logic       wb_stb,
  input  logic       wb_we,
  input  logic [2:0] wb_adr,
  input  logic [7:0] wb_dat_w,
  output logic [7:0] wb_dat_r,
  output logic       wb_ack,
  output logic [7:0] lcdc,
  output logic [7:0] scx,
  output logic [7:0] scy,
  output logic [7:0] ly,
  output logic [7:0] bgp
);

  // New request seen, ack not yet given
  logic req;

  assign req = wb_cyc && wb_stb && !wb_ack;

  // Ack for one cycle and register writes on the same edge
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wb_ack <= 1'b0;
      // Display on, BG tile data at 0x8000, BG enabled
      lcdc   <= 8'h91;
      scx    <= 8'h00;
      scy    <= 8'h00;
      ly     <= 8'h00;
      // Color 0 lightest and colors 1 to 3 darkest
      bgp    <= 8'hFC;
    end else begin
      wb_ack <= req;
      if (req && wb_we) begin
        case (wb_adr)
          ppu_pkg::reg_lcdc_adr: lcdc <= wb_dat_w;
          ppu_pkg::reg_scy_adr:  scy  <= wb_dat_w;
          ppu_pkg::reg_scx_adr:  scx  <= wb_dat_w;
          ppu_pkg::reg_ly_adr:   ly   <= wb_dat_w;
          ppu_pkg::reg_bgp_adr:  bgp  <= wb_dat_w;
          // Unmapped writes fall through here
          default: ;
        endcase
      end
    end
  end

  // Read data lands together with ack
  always_ff @(posedge clk) begin
    if (req) begin
      case (wb_adr)
        ppu_pkg::reg_lcdc_adr: wb_dat_r <= lcdc;
        ppu_pkg::reg_scy_adr:  wb_dat_r <= scy;
        ppu_pkg::reg_scx_adr:  wb_dat_r <= scx;
        ppu_pkg::reg_ly_adr:   wb_dat_r <= ly;
        ppu_pkg::reg_bgp_adr:  wb_dat_r <= bgp;
        // Open bus value
        default:               wb_dat_r <= 8'hFF;
      endcase
    end
  end

endmodule

/* list.f */
ppu_pkg.sv
lcd_regs.sv
bg_fetcher.sv
pixel_shifter.sv
ppu_bg_top.sv
ppu_bg_assertions.sv
tb_ppu_bg.sv

/* pixel_shifter.sv */
module pixel_shifter (
  input  logic       clk,
  input  logic       reset,
  input  logic       line_start,
  input  logic       row_valid,
  input  logic [7:0] row_lo,
  input  logic [7:0] row_hi,
  input  logic [7:0] lcdc,
  input  logic [7:0] scx,
  input  logic [7:0] bgp,
  output logic       row_empty,
  output logic       pixel_valid,
  output logic [1:0] pixel_shade,
  output logic [7:0] pixel_x,
  output logic       line_done
);

  // Bitplanes of the buffered row, MSB is the next pixel
  logic [7:0] buf_lo;
  logic [7:0] buf_hi;

  // Pixels left in the buffer, 0 to 8
  logic [3:0] buf_count;

  // Fine scroll pixels still to drop
  logic [2:0] discard;

  // Pixels emitted so far in this line
  logic [7:0] pix_count;

  // Line in progress
  logic active;

  logic       line_end;
  logic       shift_en;
  logic       load;
  logic [1:0] color;
  logic [1:0] shade_next;

  assign row_empty = (buf_count == 4'd0);
  assign load      = row_valid && row_empty;
  assign line_end  = (pix_count == 8'(ppu_pkg::screen_width));

  // One pixel per cycle until the line is full
  assign shift_en = active && !line_end && !row_empty;

  // Color index from the two bitplanes, BG disabled forces index 0
  assign color = lcdc[0] ? {buf_hi[7], buf_lo[7]} : 2'b00;

  // BGP holds two bits per color index
  assign shade_next = bgp[{color, 1'b0} +: 2];

  // Line framing and buffer occupancy
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      buf_count   <= 4'd0;
      discard     <= 3'd0;
      pix_count   <= 8'd0;
      active      <= 1'b0;
      pixel_valid <= 1'b0;
      line_done   <= 1'b0;
    end else begin
      pixel_valid <= 1'b0;
      line_done   <= 1'b0;
      if (line_start) begin
        // Flush whatever is left of the previous line
        buf_count <= 4'd0;
        discard   <= scx[2:0];
        pix_count <= 8'd0;
        active    <= 1'b1;
      end else begin
        if (load) begin
          buf_count <= 4'd8;
        end else if (shift_en) begin
          buf_count <= buf_count - 4'd1;
          if (discard != 3'd0) begin
            // Dropped pixel, no valid strobe
            discard <= discard - 3'd1;
          end else begin
            pixel_valid <= 1'b1;
            pix_count   <= pix_count + 8'd1;
          end
        end
        // End marker one cycle after the last pixel
        if (active && line_end) begin
          active    <= 1'b0;
          line_done <= 1'b1;
        end
      end
    end
  end

  // Row buffer and pixel payload
  always_ff @(posedge clk) begin
    if (load) begin
      buf_lo <= row_lo;
      buf_hi <= row_hi;
    end else if (shift_en) begin
      buf_lo <= {buf_lo[6:0], 1'b0};
      buf_hi <= {buf_hi[6:0], 1'b0};
    end
    if (shift_en) begin
      pixel_shade <= shade_next;
      pixel_x     <= pix_count;
    end
  end

endmodule

/* ppu_bg_assertions.sv */
module ppu_bg_assertions (
  input logic       clk,
  input logic       reset,
  input logic       wb_cyc,
  input logic       wb_stb,
  input logic       wb_ack,
  input logic       pixel_valid,
  input logic [7:0] pixel_x
);
  timeunit 1ns;
  timeprecision 1ps;

  // Ack is a single-cycle pulse
  ack_one_cycle: assert property (@(posedge clk) disable iff (reset)
    wb_ack |=> !wb_ack)
    else $error("wb_ack held for two cycles");

  // Ack only answers a request
  ack_after_req: assert property (@(posedge clk) disable iff (reset)
    wb_ack |-> $past(wb_cyc && wb_stb))
    else $error("wb_ack without cyc and stb");

  // Visible column range
  x_in_range: assert property (@(posedge clk) disable iff (reset)
    pixel_valid |-> (pixel_x < 8'(ppu_pkg::screen_width)))
    else $error("pixel_x out of range");

endmodule

bind ppu_bg_top ppu_bg_assertions ppu_bg_assertions_inst (.*);

/* ppu_bg_testdata.txt */
# lcdc scx scy ly bgp first_eight_shades, all hex
# shade of pixel x sits in bits 15-2x and 14-2x of the last column
91 00 00 00 E4 3C2A
91 00 00 00 1B C3D5
90 00 00 00 E6 AAAA
91 50 00 00 E4 CC8D
81 50 00 00 E4 0C8D
99 FB F0 14 E4 26B3
99 FB F0 14 27 E68C

/* ppu_bg_top.sv */
module ppu_bg_top (
  input  logic        clk,
  input  logic        reset,
  input  logic        wb_cyc,
  input  logic        wb_stb,
  input  logic        wb_we,
  input  logic [2:0]  wb_adr,
  input  logic [7:0]  wb_dat_w,
  input  logic        line_start,
  input  logic [7:0]  vram_rdata,
  output logic [7:0]  wb_dat_r,
  output logic        wb_ack,
  output logic [12:0] vram_addr,
  output logic        vram_rd,
  output logic        pixel_valid,
  output logic [1:0]  pixel_shade,
  output logic [7:0]  pixel_x,
  output logic        line_done
);

  // Display registers
  logic [7:0] lcdc;
  logic [7:0] scx;
  logic [7:0] scy;
  logic [7:0] ly;
  logic [7:0] bgp;

  // Row handover between fetcher and shifter
  logic       row_valid;
  logic       row_empty;
  logic [7:0] row_lo;
  logic [7:0] row_hi;

  lcd_regs lcd_regs_inst (
    .clk      (clk),
    .reset    (reset),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .lcdc     (lcdc),
    .scx      (scx),
    .scy      (scy),
    .ly       (ly),
    .bgp      (bgp)
  );

  // Map and tile data reads from external VRAM
  bg_fetcher bg_fetcher_inst (
    .clk        (clk),
    .reset      (reset),
    .line_start (line_start),
    .lcdc       (lcdc),
    .scx        (scx),
    .scy        (scy),
    .ly         (ly),
    .vram_rdata (vram_rdata),
    .row_empty  (row_empty),
    .vram_addr  (vram_addr),
    .vram_rd    (vram_rd),
    .row_valid  (row_valid),
    .row_lo     (row_lo),
    .row_hi     (row_hi)
  );

  // Fine scroll, palette and pixel output
  pixel_shifter pixel_shifter_inst (
    .clk         (clk),
    .reset       (reset),
    .line_start  (line_start),
    .row_valid   (row_valid),
    .row_lo      (row_lo),
    .row_hi      (row_hi),
    .lcdc        (lcdc),
    .scx         (scx),
    .bgp         (bgp),
    .row_empty   (row_empty),
    .pixel_valid (pixel_valid),
    .pixel_shade (pixel_shade),
    .pixel_x     (pixel_x),
    .line_done   (line_done)
  );

endmodule

/* ppu_pkg.sv */
package ppu_pkg;

  // Wishbone word addresses of the display registers
  // Addresses 1, 5 and 6 are unmapped and read back as 0xFF
  localparam logic [2:0] reg_lcdc_adr = 3'd0;
  localparam logic [2:0] reg_scy_adr  = 3'd2;
  localparam logic [2:0] reg_scx_adr  = 3'd3;
  localparam logic [2:0] reg_ly_adr   = 3'd4;
  localparam logic [2:0] reg_bgp_adr  = 3'd7;

  // Tile map offsets inside the 8 KB VRAM
  // LCDC bit 3 picks the high map
  localparam logic [12:0] map_base_low  = 13'h1800;
  localparam logic [12:0] map_base_high = 13'h1C00;

  // Tile data offsets
  // LCDC bit 4 set selects unsigned indexing from 0x0000
  // LCDC bit 4 clear selects signed indexing around 0x1000
  localparam logic [12:0] data_base_unsigned = 13'h0000;
  localparam logic [12:0] data_base_signed   = 13'h1000;

  // Visible pixels per scanline
  localparam int screen_width = 160;

  // Rows fetched per line
  // 20 rows cover 160 pixels, one more covers a fine scroll of up to 7
  localparam logic [4:0] rows_per_line = 5'd21;

  // Fetcher state codes
  // Each VRAM read is a request cycle followed by a data cycle
  localparam logic [2:0] fs_idle    = 3'd0;
  localparam logic [2:0] fs_map_req = 3'd1;
  localparam logic [2:0] fs_map_dat = 3'd2;
  localparam logic [2:0] fs_lo_req  = 3'd3;
  localparam logic [2:0] fs_lo_dat  = 3'd4;
  localparam logic [2:0] fs_hi_req  = 3'd5;
  localparam logic [2:0] fs_hi_dat  = 3'd6;
  localparam logic [2:0] fs_push    = 3'd7;

  // Tile index as read from the tile map
  // Unsigned view for the 0x8000 mode, signed view for the 0x9000 mode
  typedef union packed {
    logic [7:0]        idx_u;
    logic signed [7:0] idx_s;
  } tile_id_u;

endpackage

/* tb_ppu_bg.sv */
module tb_ppu_bg;
  timeunit 1ns;
  timeprecision 1ps;

  logic        clk;
  logic        reset;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [2:0]  wb_adr;
  logic [7:0]  wb_dat_w;
  logic        line_start;
  logic [7:0]  vram_rdata;
  logic [7:0]  wb_dat_r;
  logic        wb_ack;
  logic [12:0] vram_addr;
  logic        vram_rd;
  logic        pixel_valid;
  logic [1:0]  pixel_shade;
  logic [7:0]  pixel_x;
  logic        line_done;

  // External VRAM image
  logic [7:0] mem [0:8191];

  // Test cases from the data file
  logic [7:0]  c_lcdc [$];
  logic [7:0]  c_scx [$];
  logic [7:0]  c_scy [$];
  logic [7:0]  c_ly [$];
  logic [7:0]  c_bgp [$];
  logic [15:0] c_word [$];
  int          num_cases = 0;

  ppu_bg_top ppu_bg_top_inst (.*);

  always #5 clk = ~clk;

  // VRAM answers one cycle after the read strobe
  always @(posedge clk) begin
    if (vram_rd) begin
      vram_rdata <= mem[vram_addr];
    end
  end

  task automatic report_mismatch(input string name, input int got, input int exp);
    $display("FAIL at %0d ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  // One Wishbone classic transfer that also checks the ack latency
  task automatic wb_transfer(input logic we, input logic [2:0] adr, input logic [7:0] dat,
                             output logic [7:0] rdata);
    int waits;
    waits = 0;
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= dat;
    @(negedge clk);
    while (!wb_ack && waits < 10) begin
      @(negedge clk);
      waits++;
    end
    // Request seen on the next edge and ack right after it
    assert (waits == 1) else report_mismatch("wb_ack latency", waits, 1);
    rdata = wb_dat_r;
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic pulse_line_start;
    @(posedge clk);
    line_start <= 1'b1;
    @(posedge clk);
    line_start <= 1'b0;
  endtask

  // Reference shade for screen column x
  function automatic logic [1:0] model_shade(input int k, input int x);
    int px;
    int my;
    int map_a;
    int tile_a;
    ppu_pkg::tile_id_u id;
    logic [7:0] lo;
    logic [7:0] hi;
    int bit_n;
    int c;
    px = (c_scx[k] + x) % 256;
    my = (c_scy[k] + c_ly[k]) % 256;
    map_a = (c_lcdc[k][3] ? 'h1C00 : 'h1800) + (my / 8) * 32 + px / 8;
    id = mem[map_a];
    if (c_lcdc[k][4]) begin
      tile_a = int'(id.idx_u) * 16;
    end else begin
      tile_a = 'h1000 + int'(id.idx_s) * 16;
    end
    tile_a = tile_a + (my % 8) * 2;
    lo = mem[tile_a];
    hi = mem[tile_a + 1];
    bit_n = 7 - px % 8;
    c = c_lcdc[k][0] ? {hi[bit_n], lo[bit_n]} : 0;
    return c_bgp[k][2 * c +: 2];
  endfunction

  // Run one line or stop after 40 pixels for a partial line
  task automatic run_line(input int k, input bit full);
    int count;
    logic [15:0] word;
    count = 0;
    word = 16'h0000;
    pulse_line_start();
    forever begin
      @(negedge clk);
      if (line_done) begin
        assert (count == ppu_pkg::screen_width) else report_mismatch("pixel count", count, 160);
        break;
      end
      if (pixel_valid) begin
        assert (pixel_x == count) else report_mismatch("pixel_x", pixel_x, count);
        assert (pixel_shade == model_shade(k, count))
          else report_mismatch("pixel_shade", pixel_shade, model_shade(k, count));
        if (count < 8) begin
          word[15 - 2 * count -: 2] = pixel_shade;
        end
        count++;
        if (!full && count == 40) begin
          return;
        end
      end
    end
    assert (word == c_word[k]) else report_mismatch("first eight shades", word, c_word[k]);
  endtask

  // Watchdog sized by the number of cases
  initial begin
    wait (num_cases > 0);
    repeat ((num_cases + 1) * 2000) @(posedge clk);
    $display("Timeout: the DUT stopped producing pixels or acks");
    $display("SOME TESTS FAILED");
    $fatal(1);
  end

  initial begin
    int fd;
    string line;
    logic [7:0] v [0:4];
    logic [15:0] w;
    logic [7:0] rd;
    logic [7:0] reg_val [0:4];
    logic [2:0] reg_adr [0:4];
    clk = 1'b0;
    reset = 1'b1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = 3'd0;
    wb_dat_w = 8'h00;
    line_start = 1'b0;
    vram_rdata = 8'h00;
    for (int a = 0; a < 8192; a++) begin
      mem[a] = 8'((a % 256) * 7 + (a >> 5));
    end
    fd = $fopen("ppu_bg_testdata.txt", "r");
    if (fd == 0) begin
      $display("Could not open the test data file");
      $display("SOME TESTS FAILED");
      $fatal(1);
    end
    while (!$feof(fd)) begin
      if ($fgets(line, fd) > 0 && line[0] != "#") begin
        if ($sscanf(line, "%h %h %h %h %h %h", v[0], v[1], v[2], v[3], v[4], w) == 6) begin
          c_lcdc.push_back(v[0]);
          c_scx.push_back(v[1]);
          c_scy.push_back(v[2]);
          c_ly.push_back(v[3]);
          c_bgp.push_back(v[4]);
          c_word.push_back(w);
        end
      end
    end
    $fclose(fd);
    num_cases = c_lcdc.size();
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    // Register write and read back
    reg_adr = '{ppu_pkg::reg_lcdc_adr, ppu_pkg::reg_scy_adr, ppu_pkg::reg_scx_adr,
                ppu_pkg::reg_ly_adr, ppu_pkg::reg_bgp_adr};
    reg_val = '{8'hA5, 8'h3C, 8'h96, 8'h7E, 8'h1B};
    for (int i = 0; i < 5; i++) begin
      wb_transfer(1'b1, reg_adr[i], reg_val[i], rd);
      wb_transfer(1'b0, reg_adr[i], 8'h00, rd);
      assert (rd == reg_val[i]) else report_mismatch("wb_dat_r", rd, reg_val[i]);
    end
    // Unmapped address
    wb_transfer(1'b1, 3'd1, 8'h12, rd);
    wb_transfer(1'b0, 3'd1, 8'h00, rd);
    assert (rd == 8'hFF) else report_mismatch("wb_dat_r unmapped", rd, 8'hFF);
    for (int k = 0; k < num_cases; k++) begin
      wb_transfer(1'b1, ppu_pkg::reg_lcdc_adr, c_lcdc[k], rd);
      wb_transfer(1'b1, ppu_pkg::reg_scx_adr, c_scx[k], rd);
      wb_transfer(1'b1, ppu_pkg::reg_scy_adr, c_scy[k], rd);
      wb_transfer(1'b1, ppu_pkg::reg_ly_adr, c_ly[k], rd);
      wb_transfer(1'b1, ppu_pkg::reg_bgp_adr, c_bgp[k], rd);
      // Partial line then a restart in the middle
      run_line(k, 1'b0);
      run_line(k, 1'b1);
    end
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule
